// File: design/capt_pkg.sv
package capt_pkg;

  // ====================
  // Widths
  // ====================
  localparam int PIX_W          = 8;
  localparam int WORD_W         = 32;
  localparam int BYTES_PER_WORD = WORD_W / PIX_W;
  localparam int BE_W           = 2;
  localparam int REG_ADDR_W     = 4;
  localparam int REG_W          = 32;
  localparam int CHK_W          = 16;
  localparam int CNT_W          = 32;
  localparam int LED_W          = 4;

  typedef logic [PIX_W-1:0]      pix_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [BE_W-1:0]       be_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_W-1:0]      reg_data_t;
  typedef logic [CHK_W-1:0]      chk_t;
  typedef logic [CNT_W-1:0]      cnt_t;

  // ====================
  // Register map
  // ====================
  localparam reg_addr_t ADDR_CTRL     = 4'd0;
  localparam reg_addr_t ADDR_BYTE_CNT = 4'd1;
  localparam reg_addr_t ADDR_FRM_CHK  = 4'd2;
  localparam reg_addr_t ADDR_FRM_CNT  = 4'd3;
  localparam reg_addr_t ADDR_FRM_LEN  = 4'd4;

  // CTRL bit positions, SW_RST and CLR_CHK are self-clearing
  localparam int CTRL_EN_CAM  = 0;
  localparam int CTRL_SW_RST  = 1;
  localparam int CTRL_CLR_CHK = 2;
  localparam int CTRL_LED_LSB = 4;

endpackage

// File: design/capt_stats.sv
module capt_stats (
  input  logic             clk_board,
  input  logic             i_arst_n,
  input  logic             i_sync_clr,
  input  logic             i_clr_chk,
  word_stream_if.dst       i_word,
  output capt_pkg::cnt_t   o_byte_cnt,
  output capt_pkg::chk_t   o_frm_chk,
  output capt_pkg::cnt_t   o_frm_cnt,
  output capt_pkg::cnt_t   o_frm_len
);
  import capt_pkg::*;

  chk_t word_sum;
  chk_t run_chk;
  chk_t chk_next;
  cnt_t word_len;
  cnt_t run_len;
  cnt_t len_next;

  // Byte sum of the valid lanes only
  always_comb begin
    word_sum = '0;
    for (int k = 0; k < BYTES_PER_WORD; k++) begin
      if (k <= int'(i_word.be)) begin
        word_sum = word_sum + chk_t'(i_word.data[k*PIX_W +: PIX_W]);
      end
    end
  end

  assign word_len = cnt_t'(i_word.be) + cnt_t'(1);

  // Running totals restart on a sof word
  assign chk_next = (i_word.sof ? chk_t'(0) : run_chk) + word_sum;
  assign len_next = (i_word.sof ? cnt_t'(0) : run_len) + word_len;

  // ====================
  // Counters
  // ====================
  always_ff @(posedge clk_board or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_byte_cnt <= '0;
      o_frm_chk  <= '0;
      o_frm_cnt  <= '0;
      o_frm_len  <= '0;
      run_chk    <= '0;
      run_len    <= '0;
    end else if (i_sync_clr) begin
      o_byte_cnt <= '0;
      o_frm_chk  <= '0;
      o_frm_cnt  <= '0;
      o_frm_len  <= '0;
      run_chk    <= '0;
      run_len    <= '0;
    end else begin
      if (i_word.vld) begin
        o_byte_cnt <= o_byte_cnt + word_len;
        run_chk    <= chk_next;
        run_len    <= len_next;
      end
      // Frame close wins over a checksum clear in the same cycle
      if (i_word.vld && i_word.eof) begin
        o_frm_chk <= chk_next;
        o_frm_len <= len_next;
        o_frm_cnt <= o_frm_cnt + cnt_t'(1);
      end else if (i_clr_chk) begin
        o_frm_chk <= '0;
      end
    end
  end

endmodule

// File: design/capt_top.sv
module capt_top #(
  parameter int RST_HOLD = 8
) (
  input  logic                         clk_board,
  input  logic                         i_arst_n,
  // Register port
  input  logic                         i_reg_wr_en,
  input  capt_pkg::reg_addr_t          i_reg_addr,
  input  capt_pkg::reg_data_t          i_reg_wr_data,
  input  logic                         i_reg_rd_en,
  output capt_pkg::reg_data_t          o_reg_rd_data,
  output logic                         o_reg_rd_vld,
  // Camera bytes
  input  logic                         i_cam_vld,
  input  capt_pkg::pix_t               i_cam_data,
  input  logic                         i_cam_sof,
  input  logic                         i_cam_eof,
  // Packed words
  output logic                         o_word_vld,
  output capt_pkg::word_t              o_word_data,
  output capt_pkg::be_t                o_word_be,
  output logic                         o_word_sof,
  output logic                         o_word_eof,
  output logic [capt_pkg::LED_W-1:0]   o_led
);
  import capt_pkg::*;

  logic sync_clr;
  logic en_cam;
  logic sw_rst;
  logic clr_chk;
  cnt_t byte_cnt;
  chk_t frm_chk;
  cnt_t frm_cnt;
  cnt_t frm_len;

  word_stream_if word_if ();

  // ====================
  // Reset and registers
  // ====================
  rst_ctrl #(
    .RST_HOLD   (RST_HOLD)
  ) u_rst_ctrl (
    .clk_board  (clk_board),
    .i_arst_n   (i_arst_n),
    .i_sw_rst   (sw_rst),
    .o_sync_clr (sync_clr)
  );

  reg_decode u_reg_decode (
    .clk_board  (clk_board),
    .i_arst_n   (i_arst_n),
    .i_wr_en    (i_reg_wr_en),
    .i_addr     (i_reg_addr),
    .i_wr_data  (i_reg_wr_data),
    .i_rd_en    (i_reg_rd_en),
    .o_rd_data  (o_reg_rd_data),
    .o_rd_vld   (o_reg_rd_vld),
    .o_en_cam   (en_cam),
    .o_sw_rst   (sw_rst),
    .o_clr_chk  (clr_chk),
    .o_led      (o_led),
    .i_byte_cnt (byte_cnt),
    .i_frm_chk  (frm_chk),
    .i_frm_cnt  (frm_cnt),
    .i_frm_len  (frm_len)
  );

  // ====================
  // Capture path
  // ====================
  pixel_packer u_pixel_packer (
    .clk_board  (clk_board),
    .i_arst_n   (i_arst_n),
    .i_sync_clr (sync_clr),
    .i_en_cam   (en_cam),
    .i_vld      (i_cam_vld),
    .i_data     (i_cam_data),
    .i_sof      (i_cam_sof),
    .i_eof      (i_cam_eof),
    .o_word     (word_if.src)
  );

  capt_stats u_capt_stats (
    .clk_board  (clk_board),
    .i_arst_n   (i_arst_n),
    .i_sync_clr (sync_clr),
    .i_clr_chk  (clr_chk),
    .i_word     (word_if.dst),
    .o_byte_cnt (byte_cnt),
    .o_frm_chk  (frm_chk),
    .o_frm_cnt  (frm_cnt),
    .o_frm_len  (frm_len)
  );

  // Word stream also goes out to the pins
  assign o_word_vld  = word_if.vld;
  assign o_word_data = word_if.data;
  assign o_word_be   = word_if.be;
  assign o_word_sof  = word_if.sof;
  assign o_word_eof  = word_if.eof;

endmodule

// File: design/pixel_packer.sv
module pixel_packer (
  input  logic             clk_board,
  input  logic             i_arst_n,
  input  logic             i_sync_clr,
  input  logic             i_en_cam,
  input  logic             i_vld,
  input  capt_pkg::pix_t   i_data,
  input  logic             i_sof,
  input  logic             i_eof,
  word_stream_if.src       o_word
);
  import capt_pkg::*;

  logic  accept;
  logic  emit;
  logic  sof_held;
  be_t   idx;
  be_t   pos;
  word_t acc;
  word_t next_word;

  assign accept = i_vld && i_en_cam && !i_sync_clr;

  // A sof byte restarts at lane 0 and throws away the partial word
  assign pos  = i_sof ? be_t'(0) : idx;
  assign emit = accept && (i_eof || (pos == be_t'(BYTES_PER_WORD - 1)));

  // ====================
  // Lane merge
  // ====================
  // Lower lanes from acc, new byte at pos, upper lanes zero
  always_comb begin
    next_word = '0;
    for (int k = 0; k < BYTES_PER_WORD; k++) begin
      if (k < int'(pos)) begin
        next_word[k*PIX_W +: PIX_W] = acc[k*PIX_W +: PIX_W];
      end else if (k == int'(pos)) begin
        next_word[k*PIX_W +: PIX_W] = i_data;
      end
    end
  end

  // ====================
  // Control
  // ====================
  always_ff @(posedge clk_board or negedge i_arst_n) begin
    if (!i_arst_n) begin
      idx        <= '0;
      sof_held   <= 1'b0;
      o_word.vld <= 1'b0;
      o_word.sof <= 1'b0;
      o_word.eof <= 1'b0;
    end else if (i_sync_clr) begin
      idx        <= '0;
      sof_held   <= 1'b0;
      o_word.vld <= 1'b0;
      o_word.sof <= 1'b0;
      o_word.eof <= 1'b0;
    end else begin
      o_word.vld <= emit;
      o_word.sof <= emit && (i_sof || sof_held);
      o_word.eof <= emit && i_eof;
      if (accept) begin
        if (emit) begin
          idx      <= '0;
          sof_held <= 1'b0;
        end else begin
          idx      <= pos + be_t'(1);
          sof_held <= i_sof || sof_held;
        end
      end
    end
  end

  // Payload, qualified by vld downstream
  always_ff @(posedge clk_board) begin
    if (accept) begin
      acc <= next_word;
    end
    if (emit) begin
      o_word.data <= next_word;
      o_word.be   <= pos;
    end
  end

endmodule

// File: design/reg_decode.sv
module reg_decode (
  input  logic                         clk_board,
  input  logic                         i_arst_n,
  input  logic                         i_wr_en,
  input  capt_pkg::reg_addr_t          i_addr,
  input  capt_pkg::reg_data_t          i_wr_data,
  input  logic                         i_rd_en,
  output capt_pkg::reg_data_t          o_rd_data,
  output logic                         o_rd_vld,
  output logic                         o_en_cam,
  output logic                         o_sw_rst,
  output logic                         o_clr_chk,
  output logic [capt_pkg::LED_W-1:0]   o_led,
  input  capt_pkg::cnt_t               i_byte_cnt,
  input  capt_pkg::chk_t               i_frm_chk,
  input  capt_pkg::cnt_t               i_frm_cnt,
  input  capt_pkg::cnt_t               i_frm_len
);
  import capt_pkg::*;

  logic      ctrl_wr;
  reg_data_t ctrl_rd;
  reg_data_t rd_mux;

  assign ctrl_wr = i_wr_en && (i_addr == ADDR_CTRL);

  // ====================
  // Control register
  // ====================
  // Only the async reset clears this, so a software reset keeps it
  always_ff @(posedge clk_board or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_en_cam <= 1'b0;
      o_led    <= '0;
    end else if (ctrl_wr) begin
      o_en_cam <= i_wr_data[CTRL_EN_CAM];
      o_led    <= i_wr_data[CTRL_LED_LSB +: LED_W];
    end
  end

  // Self-clearing bits become single-cycle pulses
  always_ff @(posedge clk_board or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_sw_rst  <= 1'b0;
      o_clr_chk <= 1'b0;
    end else begin
      o_sw_rst  <= ctrl_wr && i_wr_data[CTRL_SW_RST];
      o_clr_chk <= ctrl_wr && i_wr_data[CTRL_CLR_CHK];
    end
  end

  // ====================
  // Readback
  // ====================
  // Pulse bits always read back as zero
  always_comb begin
    ctrl_rd                          = '0;
    ctrl_rd[CTRL_EN_CAM]             = o_en_cam;
    ctrl_rd[CTRL_LED_LSB +: LED_W]   = o_led;
  end

  always_comb begin
    case (i_addr)
      ADDR_CTRL: begin
        rd_mux = ctrl_rd;
      end
      ADDR_BYTE_CNT: begin
        rd_mux = reg_data_t'(i_byte_cnt);
      end
      ADDR_FRM_CHK: begin
        rd_mux = reg_data_t'(i_frm_chk);
      end
      ADDR_FRM_CNT: begin
        rd_mux = reg_data_t'(i_frm_cnt);
      end
      ADDR_FRM_LEN: begin
        rd_mux = reg_data_t'(i_frm_len);
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  always_ff @(posedge clk_board or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rd_vld <= 1'b0;
    end else begin
      o_rd_vld <= i_rd_en;
    end
  end

  // Data is only looked at with o_rd_vld
  always_ff @(posedge clk_board) begin
    if (i_rd_en) begin
      o_rd_data <= rd_mux;
    end
  end

endmodule

// File: design/rst_ctrl.sv
module rst_ctrl #(
  parameter int RST_HOLD = 8
) (
  input  logic clk_board,
  input  logic i_arst_n,
  input  logic i_sw_rst,
  output logic o_sync_clr
);

  localparam int HOLD_W = $clog2(RST_HOLD + 1);

  logic [1:0]        rel_sync;
  logic [HOLD_W-1:0] hold_cnt;

  // ====================
  // Release sync
  // ====================
  // Two flops, assert async and release on the clock
  always_ff @(posedge clk_board or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rel_sync <= '0;
    end else begin
      rel_sync <= {rel_sync[0], 1'b1};
    end
  end

  // ====================
  // Clear stretch
  // ====================
  // Counter parked at full hold until the release gets through
  always_ff @(posedge clk_board or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hold_cnt <= HOLD_W'(RST_HOLD);
    end else if (!rel_sync[1]) begin
      hold_cnt <= HOLD_W'(RST_HOLD);
    end else if (i_sw_rst) begin
      // Pulse cycle itself counts as the first one
      hold_cnt <= HOLD_W'(RST_HOLD - 1);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - HOLD_W'(1);
    end
  end

  assign o_sync_clr = !rel_sync[1] || i_sw_rst || (hold_cnt != '0);

endmodule

// File: design/word_stream_if.sv
interface word_stream_if;
  import capt_pkg::*;

  // One strobe per packed word, no back-pressure
  logic  vld;
  word_t data;
  // Valid bytes minus one
  be_t   be;
  logic  sof;
  logic  eof;

  modport src (
    output vld,
    output data,
    output be,
    output sof,
    output eof
  );

  modport dst (
    input vld,
    input data,
    input be,
    input sof,
    input eof
  );

endinterface

// File: files.f
design/capt_pkg.sv
design/word_stream_if.sv
design/rst_ctrl.sv
design/reg_decode.sv
design/pixel_packer.sv
design/capt_stats.sv
design/capt_top.sv
tb/capt_props.sv
tb/tb_capt_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the capture testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module tb_capt_top -Mdir obj_dir -o sim_capt
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_capt > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0

// File: tb/capt_props.sv
module capt_props (
  input logic clk_board,
  input logic i_arst_n,
  input logic i_cam_vld,
  input logic i_en_cam,
  input logic i_sync_clr,
  input logic i_word_vld,
  input logic i_word_sof,
  input logic i_word_eof,
  input logic i_rd_en,
  input logic i_rd_vld
);
  timeunit 1ns;
  timeprecision 1ps;

  logic accepted;

  assign accepted = i_cam_vld && i_en_cam && !i_sync_clr;

  // A word always follows an accepted byte by one cycle
  word_needs_byte: assert property (@(posedge clk_board) disable iff (!i_arst_n)
    i_word_vld |-> $past(accepted))
    else $error("Word strobe without an accepted byte one cycle earlier");

  flags_need_vld: assert property (@(posedge clk_board) disable iff (!i_arst_n)
    (i_word_sof || i_word_eof) |-> i_word_vld)
    else $error("Frame flag high without a word strobe");

  rd_vld_follows: assert property (@(posedge clk_board) disable iff (!i_arst_n)
    i_rd_vld == $past(i_rd_en))
    else $error("Read valid does not follow the read strobe by one cycle");

endmodule

bind capt_top capt_props u_capt_props (
  .clk_board  (clk_board),
  .i_arst_n   (i_arst_n),
  .i_cam_vld  (i_cam_vld),
  .i_en_cam   (en_cam),
  .i_sync_clr (sync_clr),
  .i_word_vld (o_word_vld),
  .i_word_sof (o_word_sof),
  .i_word_eof (o_word_eof),
  .i_rd_en    (i_reg_rd_en),
  .i_rd_vld   (o_reg_rd_vld)
);

// File: tb/tb_capt_top.sv
module tb_capt_top;
  timeunit 1ns;
  timeprecision 1ps;
  import capt_pkg::*;

  localparam int RST_HOLD = 8;
  localparam int N_FRAMES = 12;
  localparam int MAX_LEN  = 40;

  logic                   clk_board = 1'b0;
  logic                   i_arst_n;
  logic                   i_reg_wr_en;
  reg_addr_t              i_reg_addr;
  reg_data_t              i_reg_wr_data;
  logic                   i_reg_rd_en;
  reg_data_t              o_reg_rd_data;
  logic                   o_reg_rd_vld;
  logic                   i_cam_vld;
  pix_t                   i_cam_data;
  logic                   i_cam_sof;
  logic                   i_cam_eof;
  logic                   o_word_vld;
  word_t                  o_word_data;
  be_t                    o_word_be;
  logic                   o_word_sof;
  logic                   o_word_eof;
  logic [LED_W-1:0]       o_led;

  logic [31:0]            lfsr = 32'he215;
  int                     err_cnt = 0;
  int                     chk_cnt = 0;
  int                     budget_cycles = 0;
  int                     frm_lens [N_FRAMES];
  // Expected word as {sof, eof, be, data}
  logic [WORD_W+BE_W+1:0] exp_q [$];
  logic [WORD_W+BE_W+1:0] got;
  cnt_t                   m_byte_cnt;
  cnt_t                   m_frm_cnt;
  cnt_t                   m_frm_len;
  chk_t                   m_frm_chk;
  logic [LED_W-1:0]       m_led;

  capt_top #(.RST_HOLD(RST_HOLD)) dut0 (.*);

  always #2 clk_board = ~clk_board;

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  // One step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic reg_data_t ctrl_word(input logic en, input logic [LED_W-1:0] led);
    return (reg_data_t'(led) << CTRL_LED_LSB) | reg_data_t'(en);
  endfunction

  task automatic wr_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk_board);
    i_reg_wr_en   = 1'b1;
    i_reg_addr    = addr;
    i_reg_wr_data = data;
    @(negedge clk_board);
    i_reg_wr_en   = 1'b0;
  endtask

  // Data is due exactly one cycle after the strobe
  task automatic rd_check(input reg_addr_t addr, input reg_data_t exp, input string name);
    @(negedge clk_board);
    i_reg_rd_en = 1'b1;
    i_reg_addr  = addr;
    @(negedge clk_board);
    i_reg_rd_en = 1'b0;
    chk_cnt += 2;
    assert (o_reg_rd_vld) else begin
      err_cnt++;
      $display("Read of %s gave no valid strobe one cycle later", name);
    end
    assert (o_reg_rd_data == exp) else begin
      err_cnt++;
      $display("FAIL %s: expected %h, actual %h", name, exp, o_reg_rd_data);
    end
  endtask

  task automatic check_stats(input string tag);
    rd_check(ADDR_BYTE_CNT, reg_data_t'(m_byte_cnt), {tag, " byte_cnt"});
    rd_check(ADDR_FRM_CHK, reg_data_t'(m_frm_chk), {tag, " frm_chk"});
    rd_check(ADDR_FRM_CNT, reg_data_t'(m_frm_cnt), {tag, " frm_cnt"});
    rd_check(ADDR_FRM_LEN, reg_data_t'(m_frm_len), {tag, " frm_len"});
  endtask

  // Idle gaps are random and model words are queued before their bytes go out
  task automatic send_frame(input int len, input bit expect_words);
    pix_t  px;
    word_t w;
    int    lane;
    chk_t  sum;
    sum = '0;
    w   = '0;
    for (int i = 0; i < len; i++) begin
      repeat (int'(take_bits(2))) begin
        @(negedge clk_board);
        i_cam_vld = 1'b0;
      end
      px   = pix_t'(take_bits(8));
      lane = i % BYTES_PER_WORD;
      w[lane*PIX_W +: PIX_W] = px;
      sum  = sum + chk_t'(px);
      if (lane == BYTES_PER_WORD - 1 || i == len - 1) begin
        if (expect_words) begin
          exp_q.push_back({i < BYTES_PER_WORD, i == len - 1, be_t'(lane), w});
        end
        w = '0;
      end
      @(negedge clk_board);
      i_cam_vld  = 1'b1;
      i_cam_data = px;
      i_cam_sof  = (i == 0);
      i_cam_eof  = (i == len - 1);
    end
    @(negedge clk_board);
    i_cam_vld = 1'b0;
    i_cam_sof = 1'b0;
    i_cam_eof = 1'b0;
    if (expect_words) begin
      m_byte_cnt = m_byte_cnt + cnt_t'(len);
      m_frm_chk  = sum;
      m_frm_len  = cnt_t'(len);
      m_frm_cnt  = m_frm_cnt + cnt_t'(1);
    end
  endtask

  task automatic drain_words();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 8) begin
      @(negedge clk_board);
      waited++;
    end
    chk_cnt++;
    assert (exp_q.size() == 0) else begin
      err_cnt++;
      $display("Packer never sent %0d expected words", exp_q.size());
    end
    // Statistics land one cycle after the last word
    @(negedge clk_board);
  endtask

  // ====================
  // Word monitor
  // ====================
  always @(negedge clk_board) begin
    if (o_word_vld) begin
      chk_cnt++;
      assert (exp_q.size() != 0) else begin
        err_cnt++;
        $display("Packer sent word %h when none was expected", o_word_data);
      end
      if (exp_q.size() != 0) begin
        got = {o_word_sof, o_word_eof, o_word_be, o_word_data};
        assert (got == exp_q[0]) else begin
          err_cnt++;
          $display("FAIL word: expected %h, actual %h", exp_q[0], got);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  // Budget is four cycles per byte plus register traffic per frame
  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk_board);
    $display("Watchdog expired after %0d cycles with the run unfinished", budget_cycles);
    $display("Some tests failed");
    $finish;
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    int total;
    i_arst_n      = 1'b0;
    i_reg_wr_en   = 1'b0;
    i_reg_addr    = '0;
    i_reg_wr_data = '0;
    i_reg_rd_en   = 1'b0;
    i_cam_vld     = 1'b0;
    i_cam_data    = '0;
    i_cam_sof     = 1'b0;
    i_cam_eof     = 1'b0;
    m_byte_cnt    = '0;
    m_frm_cnt     = '0;
    m_frm_len     = '0;
    m_frm_chk     = '0;
    total         = 0;
    for (int f = 0; f < N_FRAMES; f++) begin
      frm_lens[f] = int'(take_bits(6)) % MAX_LEN + 1;
      total += frm_lens[f];
    end
    budget_cycles = 4 * (total + 3 * MAX_LEN) + 40 * (N_FRAMES + 6) + 4 * RST_HOLD;
    repeat (3) @(negedge clk_board);
    i_arst_n = 1'b1;
    repeat (RST_HOLD + 4) @(negedge clk_board);
    check_stats("reset");
    rd_check(ADDR_CTRL, '0, "reset ctrl");

    m_led = LED_W'(take_bits(4));
    wr_reg(ADDR_CTRL, ctrl_word(1'b1, m_led));
    for (int f = 0; f < N_FRAMES; f++) begin
      send_frame(frm_lens[f], 1'b1);
      drain_words();
      check_stats("frame");
    end

    // Capture disabled
    wr_reg(ADDR_CTRL, ctrl_word(1'b0, m_led));
    send_frame(frm_lens[0], 1'b0);
    drain_words();
    check_stats("disabled");

    // Checksum clear together with a new LED value
    // New LED value always differs from the old one in bit 0
    m_led = m_led ^ (LED_W'(take_bits(3)) << 1) ^ LED_W'(1);
    wr_reg(ADDR_CTRL, ctrl_word(1'b1, m_led) | (reg_data_t'(1) << CTRL_CLR_CHK));
    m_frm_chk = '0;
    chk_cnt++;
    assert (o_led == m_led) else begin
      err_cnt++;
      $display("FAIL led: expected %h, actual %h", m_led, o_led);
    end
    rd_check(ADDR_CTRL, ctrl_word(1'b1, m_led), "led ctrl");
    check_stats("clr_chk");

    // Fresh frame so every statistic is nonzero before the reset
    send_frame(frm_lens[1], 1'b1);
    drain_words();
    check_stats("pre sw_rst");

    // Software reset keeps CTRL
    wr_reg(ADDR_CTRL, ctrl_word(1'b1, m_led) | (reg_data_t'(1) << CTRL_SW_RST));
    m_byte_cnt = '0;
    m_frm_cnt  = '0;
    m_frm_len  = '0;
    m_frm_chk  = '0;
    repeat (RST_HOLD + 4) @(negedge clk_board);
    check_stats("sw_rst");
    rd_check(ADDR_CTRL, ctrl_word(1'b1, m_led), "sw_rst ctrl");
    send_frame(7, 1'b1);
    drain_words();
    check_stats("after sw_rst");

    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
